//--- all.f
+incdir+.
dnaAlphabetPkg.sv
dnaControlPkg.sv
symbolMemory.sv
matchCompare.sv
matchControl.sv
dnaMatcher.sv
dnaMatcher_properties.sv
dnaMatcher_tb.sv

//--- dnaAlphabetPkg.sv
`include "dna_defines.svh"

package dnaAlphabetPkg;

    typedef enum logic [1:0] {
        baseA = 2'd0,
        baseC = 2'd1,
        baseT = 2'd2,
        baseG = 2'd3
    } base_t;

    // Literal codes line up with base_t
    typedef enum logic [2:0] {
        tokA         = 3'd0,
        tokC         = 3'd1,
        tokT         = 3'd2,
        tokG         = 3'd3,
        tokPairOpen  = 3'd4,
        tokReserved5 = 3'd5,
        tokReserved6 = 3'd6,
        tokPatEnd    = 3'd7
    } token_t;

    typedef enum logic [2:0] {
        litMatch  = 3'd0,
        litMiss   = 3'd1,
        pairOpen  = 3'd2,
        pairMatch = 3'd3,
        pairMiss  = 3'd4,
        patEnd    = 3'd5,
        badToken  = 3'd6
    } notify_t;

    typedef struct packed {
        logic                   valid;
        logic [`SEQ_ADDR_W-1:0] addr;
        base_t                  data;
    } seqWrite_t;

    typedef struct packed {
        logic                   valid;
        logic [`PAT_ADDR_W-1:0] addr;
        token_t                 data;
    } patWrite_t;

endpackage

//--- dnaControlPkg.sv
package dnaControlPkg;

    typedef enum logic [3:0] {
        idle      = 4'd0,
        readToken = 4'd1,
        readAlt1  = 4'd2,
        readAlt2  = 4'd3,
        compare   = 4'd4,
        matched   = 4'd5,
        noMatch   = 4'd6,
        patError  = 4'd7
    } ctrlState_t;

    // Strobes from the controller to both memories and the comparator
    typedef struct packed {
        logic seqClear;
        logic seqAdvance;
        logic patClear;
        logic patAdvance;
        logic altLoad;     // Capture first choice of a group
    } memCtrl_t;

    typedef struct packed {
        logic done;
        logic found;
        logic error;
    } matchResult_t;

endpackage

//--- dnaMatcher.sv
`timescale 1ns/1ps
`include "dna_defines.svh"

module dnaMatcher
    import dnaAlphabetPkg::*, dnaControlPkg::*;
(
    input  logic                 clock,
    input  logic                 reset_N,
    input  logic                 start,
    input  seqWrite_t            seqWrite,
    input  patWrite_t            patWrite,
    input  logic [`SEQ_ADDR_W:0] seqLength,
    output matchResult_t         result
);

    localparam logic [`PAT_ADDR_W:0] PAT_LIMIT = `PAT_DEPTH;

    memCtrl_t ctrl;
    base_t    curBase;
    token_t   curToken;
    notify_t  notify;
    logic     seqAtEnd;

    symbolMemory #(
        .symbol_t (base_t),
        .DEPTH    (`SEQ_DEPTH),
        .ADDR_W   (`SEQ_ADDR_W)
    ) seqMem (
        .clock     (clock),
        .reset_N   (reset_N),
        .writeEn   (seqWrite.valid),
        .writeAddr (seqWrite.addr),
        .writeData (seqWrite.data),
        .clear     (ctrl.seqClear),
        .advance   (ctrl.seqAdvance),
        .limit     (seqLength),
        .readData  (curBase),
        .atEnd     (seqAtEnd)
    );

    symbolMemory #(
        .symbol_t (token_t),
        .DEPTH    (`PAT_DEPTH),
        .ADDR_W   (`PAT_ADDR_W)
    ) patMem (
        .clock     (clock),
        .reset_N   (reset_N),
        .writeEn   (patWrite.valid),
        .writeAddr (patWrite.addr),
        .writeData (patWrite.data),
        .clear     (ctrl.patClear),
        .advance   (ctrl.patAdvance),
        .limit     (PAT_LIMIT),
        .readData  (curToken),
        .atEnd     ()                  // Pattern end comes from the token
    );

    matchCompare compareUnit (
        .clock   (clock),
        .reset_N (reset_N),
        .ctrl    (ctrl),
        .token   (curToken),
        .base    (curBase),
        .notify  (notify)
    );

    matchControl controlUnit (
        .clock    (clock),
        .reset_N  (reset_N),
        .start    (start),
        .notify   (notify),
        .seqAtEnd (seqAtEnd),
        .ctrl     (ctrl),
        .result   (result)
    );

endmodule

//--- dnaMatcher_properties.sv
`timescale 1ns/1ps

module dnaMatcher_properties
    import dnaControlPkg::*;
(
    input logic         clock,
    input logic         reset_N,
    input logic         start,
    input matchResult_t result
);

    assert property (@(posedge clock) disable iff (!reset_N)
        !(result.found && result.error))
        else $error("found and error are high together");

    // Flags only valid alongside done
    assert property (@(posedge clock) disable iff (!reset_N)
        !result.done |-> (!result.found && !result.error))
        else $error("found or error is high while done is low");

    assert property (@(posedge clock) disable iff (!reset_N)
        start |=> !result.done)
        else $error("done is still high in the cycle after start");

endmodule

bind dnaMatcher dnaMatcher_properties i_props (
    .clock   (clock),
    .reset_N (reset_N),
    .start   (start),
    .result  (result)
);

//--- dnaMatcher_tb.sv
`timescale 1ns/1ps
`include "dna_defines.svh"

module dnaMatcher_tb
    import dnaAlphabetPkg::*, dnaControlPkg::*;
();

    localparam int SLOTS        = 8;    // Bases and tokens per case
    localparam int WAIT_LIMIT   = 200;
    localparam int RANDOM_CASES = 20;

    typedef struct packed {
        logic [SLOTS-1:0][1:0] seq;      // Entry i is base i
        logic [`SEQ_ADDR_W:0]  len;
        logic [SLOTS-1:0][2:0] pat;
        matchResult_t          want;
    } caseEntry_t;

    logic                 clock = 1'b0;
    logic                 reset_N;
    logic                 start;
    seqWrite_t            seqWrite;
    patWrite_t            patWrite;
    logic [`SEQ_ADDR_W:0] seqLength;
    matchResult_t         result;

    caseEntry_t  caseTable [$];
    base_t       seqImage [`SEQ_DEPTH];
    token_t      patImage [`PAT_DEPTH];
    logic [15:0] lfsrState = 16'd43;

    dnaMatcher i_dut (
        .clock     (clock),
        .reset_N   (reset_N),
        .start     (start),
        .seqWrite  (seqWrite),
        .patWrite  (patWrite),
        .seqLength (seqLength),
        .result    (result)
    );

    always #4 clock = ~clock;

    // Galois LFSR stepped once per bit
    function automatic logic lfsrBit();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 16'hB400;
        end
        return outBit;
    endfunction

    function automatic logic [7:0] randBits(input int count);
        logic [7:0] value;
        int         i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value = {value[6:0], lfsrBit()};
        end
        return value;
    endfunction

    function automatic base_t baseOf(input byte c);
        case (c)
            "C":     return baseC;
            "T":     return baseT;
            "G":     return baseG;
            default: return baseA;
        endcase
    endfunction

    // P opens a pair and 5 or 6 is reserved while anything else ends the pattern
    function automatic token_t tokenOf(input byte c);
        case (c)
            "A":     return tokA;
            "C":     return tokC;
            "T":     return tokT;
            "G":     return tokG;
            "P":     return tokPairOpen;
            "5":     return tokReserved5;
            "6":     return tokReserved6;
            default: return tokPatEnd;
        endcase
    endfunction

    // Matching rule applied to the memory images
    function automatic matchResult_t expectedResult(input logic [`SEQ_ADDR_W:0] len);
        matchResult_t           res;
        logic [`PAT_ADDR_W-1:0] p;
        logic [`SEQ_ADDR_W:0]   s;
        token_t                 tok;
        token_t                 alt1;
        token_t                 alt2;
        base_t                  cur;
        logic                   busy;
        int                     step;
        res  = '{done: 1'b1, found: 1'b0, error: 1'b0};
        p    = '0;
        s    = '0;
        busy = 1'b1;
        step = 0;
        while (busy && step < 40) begin
            step++;
            tok = patImage[p];
            cur = seqImage[s[`SEQ_ADDR_W-1:0]];
            alt1 = patImage[p + 4'd1];
            alt2 = patImage[p + 4'd2];
            if (tok == tokPatEnd) begin
                res.found = 1'b1;
                busy      = 1'b0;
            end else if (tok == tokReserved5 || tok == tokReserved6) begin
                res.error = 1'b1;
                busy      = 1'b0;
            end else if (tok == tokPairOpen) begin
                if (alt1[2] || alt2[2] || alt1 == alt2) begin
                    res.error = 1'b1;
                    busy      = 1'b0;
                end else if (s == len) begin
                    busy = 1'b0;
                end else if (cur == base_t'(alt1[1:0]) || cur == base_t'(alt2[1:0])) begin
                    s = s + 1'b1;
                    p = p + 4'd3;
                end else begin
                    busy = 1'b0;
                end
            end else if (s != len && cur == base_t'(tok[1:0])) begin
                s = s + 1'b1;
                p = p + 1'b1;
            end else begin
                busy = 1'b0;        // Sequence ended or literal missed
            end
        end
        return res;
    endfunction

    task automatic addCase(input string seqText, input int len, input string patText,
                           input logic isFound, input logic isError);
        caseEntry_t entry;
        int         i;
        entry = '0;
        for (i = 0; i < SLOTS; i++) begin
            entry.seq[i] = (i < seqText.len()) ? baseOf(seqText[i]) : baseA;
            entry.pat[i] = (i < patText.len()) ? tokenOf(patText[i]) : tokPatEnd;
        end
        entry.len  = len[`SEQ_ADDR_W:0];
        entry.want = '{done: 1'b1, found: isFound, error: isError};
        loadImages(entry);
        if (expectedResult(entry.len) !== entry.want) begin
            $display("Table case %0d disagrees with the reference model", caseTable.size());
            $display("TESTS FAILED");
            $fatal(1, "Case table inconsistent");
        end
        caseTable.push_back(entry);
    endtask

    task automatic buildTable();
        addCase("ACGT", 4, "ACG$", 1'b1, 1'b0);
        addCase("ACGT", 4, "ACGT$", 1'b1, 1'b0);
        addCase("ACGT", 4, "AG$", 1'b0, 1'b0);
        addCase("AC", 2, "ACG$", 1'b0, 1'b0);
        addCase("ACGT", 2, "ACG$", 1'b0, 1'b0);
        addCase("GA", 2, "PGTA$", 1'b1, 1'b0);
        addCase("TA", 2, "PGT$", 1'b1, 1'b0);
        addCase("CA", 2, "PGT$", 1'b0, 1'b0);
        addCase("GA", 2, "PGG$", 1'b0, 1'b1);
        addCase("A", 1, "PA5$", 1'b0, 1'b1);
        addCase("A", 1, "PPA$", 1'b0, 1'b1);
        addCase("A", 1, "A6$", 1'b0, 1'b1);
        addCase("AC", 2, "ACPTT$", 1'b0, 1'b1);   // Repeat after sequence end
        addCase("AC", 2, "AC6$", 1'b0, 1'b1);
        addCase("AC", 2, "ACPAG$", 1'b0, 1'b0);
        addCase("", 0, "$", 1'b1, 1'b0);
        addCase("", 0, "A$", 1'b0, 1'b0);
        addCase("ACGTACGT", 8, "ACGTACGT", 1'b1, 1'b0);
    endtask

    task automatic loadImages(input caseEntry_t entry);
        int i;
        for (i = 0; i < `SEQ_DEPTH; i++) begin
            if (i < SLOTS) begin
                seqImage[i] = base_t'(entry.seq[i]);
                patImage[i] = token_t'(entry.pat[i]);
            end else begin
                seqImage[i] = base_t'(i[3:2] ^ i[1:0]);
                patImage[i] = tokPatEnd;
            end
        end
    endtask

    // Prefix copies with an occasional changed literal
    task automatic addRandomCases();
        caseEntry_t entry;
        logic [7:0] bits;
        int         n;
        int         i;
        int         prefix;
        int         flipAt;
        for (n = 0; n < RANDOM_CASES; n++) begin
            entry = '0;
            for (i = 0; i < SLOTS; i++) begin
                bits         = randBits(2);
                entry.seq[i] = bits[1:0];
                entry.pat[i] = tokPatEnd;
            end
            bits      = randBits(3);
            entry.len = {2'b00, bits[2:0]} + 5'd1;
            bits      = randBits(3);
            prefix    = int'(bits[2:0]);
            for (i = 0; i < prefix; i++) begin
                entry.pat[i] = {1'b0, entry.seq[i]};
            end
            bits = randBits(1);
            if (bits[0] && prefix > 0) begin
                bits   = randBits(3);
                flipAt = int'(bits[2:0]) % prefix;
                bits   = randBits(2);
                entry.pat[flipAt][1:0] = entry.pat[flipAt][1:0] ^ (bits[1:0] | 2'b01);
            end
            loadImages(entry);
            entry.want = expectedResult(entry.len);
            caseTable.push_back(entry);
        end
    endtask

    task automatic initInputs();
        reset_N   <= 1'b0;
        start     <= 1'b0;
        seqWrite  <= '0;
        patWrite  <= '0;
        seqLength <= '0;
    endtask

    task automatic applyReset();
        repeat (8) @(posedge clock);
        reset_N <= 1'b1;
    endtask

    task automatic checkResult(input int idx, input matchResult_t got, input matchResult_t want);
        if (got !== want) begin
            $display("ERR result case %0d got %h expected %h", idx, got, want);
            $display("TESTS FAILED");
            $fatal(1, "Result mismatch");
        end
    endtask

    task automatic runCase(input caseEntry_t entry, input int idx);
        int i;
        int waitCount;
        loadImages(entry);
        for (i = 0; i < `SEQ_DEPTH; i++) begin
            @(posedge clock);
            seqWrite <= '{valid: 1'b1, addr: i[`SEQ_ADDR_W-1:0], data: seqImage[i]};
            patWrite <= '{valid: 1'b1, addr: i[`PAT_ADDR_W-1:0], data: patImage[i]};
        end
        @(posedge clock);
        seqWrite.valid <= 1'b0;
        patWrite.valid <= 1'b0;
        seqLength      <= entry.len;
        start          <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        waitCount = 0;
        @(negedge clock);
        while (!result.done && waitCount < WAIT_LIMIT) begin
            @(negedge clock);
            waitCount++;
        end
        if (!result.done) begin
            $display("Case %0d: done did not rise within %0d cycles", idx, WAIT_LIMIT);
            $display("TESTS FAILED");
            $fatal(1, "Timeout waiting for done");
        end
        checkResult(idx, result, entry.want);
        repeat (3) @(negedge clock);
        checkResult(idx, result, entry.want);   // Held until next start
    endtask

    initial begin
        int idx;
        initInputs();
        applyReset();
        buildTable();
        addRandomCases();
        for (idx = 0; idx < caseTable.size(); idx++) begin
            runCase(caseTable[idx], idx);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- dna_defines.svh
`ifndef DNA_DEFINES_SVH
`define DNA_DEFINES_SVH

// Sequence memory geometry
`define SEQ_DEPTH 16
`define SEQ_ADDR_W 4

// Pattern memory geometry
`define PAT_DEPTH 16
`define PAT_ADDR_W 4

`endif

//--- matchCompare.sv
`timescale 1ns/1ps

module matchCompare
    import dnaAlphabetPkg::*, dnaControlPkg::*;
(
    input  logic     clock,
    input  logic     reset_N,
    input  memCtrl_t ctrl,
    input  token_t   token,
    input  base_t    base,
    output notify_t  notify
);

    token_t altFirst;
    logic   altValid;      // Second choice is the current token
    logic   firstLit;
    logic   secondLit;
    logic   pairDistinct;
    logic   pairHit;

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            altValid <= 1'b0;
        end else if (ctrl.patClear) begin
            altValid <= 1'b0;
        end else if (ctrl.altLoad) begin
            altValid <= 1'b1;
        end else if (ctrl.patAdvance) begin
            altValid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.altLoad) begin
            altFirst <= token;
        end
    end

    always_comb begin
        firstLit     = ~altFirst[2];
        secondLit    = ~token[2];
        pairDistinct = (altFirst[1:0] != token[1:0]);
        pairHit      = (base_t'(altFirst[1:0]) == base) || (base_t'(token[1:0]) == base);

        if (altValid) begin
            if (!firstLit || !secondLit || !pairDistinct) begin
                notify = badToken;
            end else if (pairHit) begin
                notify = pairMatch;
            end else begin
                notify = pairMiss;
            end
        end else begin
            unique case (token)
                tokA, tokC, tokT, tokG: notify = (base_t'(token[1:0]) == base) ? litMatch : litMiss;
                tokPairOpen:            notify = pairOpen;
                tokPatEnd:              notify = patEnd;
                default:                notify = badToken;   // Reserved codes
            endcase
        end
    end

endmodule

//--- matchControl.sv
`timescale 1ns/1ps

module matchControl
    import dnaAlphabetPkg::*, dnaControlPkg::*;
(
    input  logic         clock,
    input  logic         reset_N,
    input  logic         start,
    input  notify_t      notify,
    input  logic         seqAtEnd,
    output memCtrl_t     ctrl,
    output matchResult_t result
);

    ctrlState_t state;
    ctrlState_t nextState;

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        ctrl      = '0;

        unique case (state)
            idle, matched, noMatch, patError: begin
                if (start) begin
                    ctrl.seqClear = 1'b1;
                    ctrl.patClear = 1'b1;
                    nextState     = readToken;
                end
            end

            readToken: begin
                case (notify)
                    patEnd: begin
                        nextState = matched;
                    end
                    badToken: begin
                        nextState = patError;
                    end
                    pairOpen: begin
                        ctrl.patAdvance = 1'b1;   // Step onto first choice
                        nextState       = readAlt1;
                    end
                    default: begin
                        nextState = compare;
                    end
                endcase
            end

            readAlt1: begin
                ctrl.altLoad    = 1'b1;
                ctrl.patAdvance = 1'b1;
                nextState       = readAlt2;
            end

            readAlt2: begin
                // Bad or repeated choice wins over a finished sequence
                if (notify == badToken) begin
                    nextState = patError;
                end else begin
                    nextState = compare;
                end
            end

            compare: begin
                if (seqAtEnd) begin
                    nextState = noMatch;
                end else if (notify == litMatch || notify == pairMatch) begin
                    ctrl.seqAdvance = 1'b1;
                    ctrl.patAdvance = 1'b1;
                    nextState       = readToken;
                end else begin
                    nextState = noMatch;
                end
            end

            default: begin
                nextState = idle;
            end
        endcase
    end

    // Result follows the held state
    always_comb begin
        result.done  = (state == matched) || (state == noMatch) || (state == patError);
        result.found = (state == matched);
        result.error = (state == patError);
    end

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the dnaMatcher testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module dnaMatcher_tb \
    --Mdir obj_dir -o dnaMatcher_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/dnaMatcher_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

//--- symbolMemory.sv
`timescale 1ns/1ps

module symbolMemory #(
    parameter type symbol_t = logic [1:0],
    parameter int  DEPTH    = 16,
    parameter int  ADDR_W   = 4
) (
    input  logic              clock,
    input  logic              reset_N,
    input  logic              writeEn,
    input  logic [ADDR_W-1:0] writeAddr,
    input  symbol_t           writeData,
    input  logic              clear,
    input  logic              advance,
    input  logic [ADDR_W:0]   limit,
    output symbol_t           readData,
    output logic              atEnd
);

    symbol_t         storage [DEPTH];
    logic [ADDR_W:0] readCount;    // One extra bit so a full memory can be counted

    always_ff @(posedge clock) begin
        if (writeEn) begin
            storage[writeAddr] <= writeData;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_N) begin
            readCount <= '0;
        end else if (clear) begin
            readCount <= '0;
        end else if (advance) begin
            readCount <= readCount + 1'b1;
        end
    end

    // Read is combinational from the counter
    assign readData = storage[readCount[ADDR_W-1:0]];

    assign atEnd = (readCount == limit);

endmodule
